// ==== tb.f ====
hdl/lab4_pkg.sv
hdl/lab4_interval_timer.sv
hdl/lab4_ctrl_regs.sv
hdl/lab4_ramp_fsm.sv
hdl/lab4_serial_shifter.sv
hdl/lab4_controller.sv
+incdir+verif
verif/tb_lab4_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_lab4_controller -o sim_lab4

# the log decides the outcome
./obj_dir/sim_lab4 > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// ==== verif/tb_lab4_checks.svh ====
`ifndef TB_LAB4_CHECKS_SVH
`define TB_LAB4_CHECKS_SVH

// bus response, ack and read data together
task automatic check_rsp(input string what, input bus_rsp_t got, input bus_rsp_t exp);
	if (got !== exp) begin
		report_error($sformatf("%s: ack %0b data %h, expected ack %0b data %h",
			what, got.ack, got.rdata, exp.ack, exp.rdata));
	end
endtask

// word seen on one chip plus the set of chips that toggled
task automatic check_serial(input string what, input logic [SERIAL_W-1:0] got_word,
		input logic [SERIAL_W-1:0] exp_word, input logic [NUM_CHIPS-1:0] got_mask,
		input logic [NUM_CHIPS-1:0] exp_mask);
	if (got_mask !== exp_mask) begin
		report_error($sformatf("%s: chip mask %h, expected %h", what, got_mask, exp_mask));
	end
	if (got_word !== exp_word) begin
		report_error($sformatf("%s: word %h, expected %h", what, got_word, exp_word));
	end
endtask

task automatic check_count(input string what, input wilk_count_t got, input wilk_count_t exp);
	if (got !== exp) begin
		report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
	end
endtask

// output levels, zero extended
task automatic check_level(input string what, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
	if (got !== exp) begin
		report_error($sformatf("%s: got %h, expected %h", what, got, exp));
	end
endtask

`endif

// ==== verif/tb_lab4_controller.sv ====
`timescale 1ns/1ps

module tb_lab4_controller;

	import lab4_pkg::*;

	localparam int NUM_CHIPS    = 12;
	localparam int RESET_CYCLES = 10;

	typedef enum logic [3:0] {
		OP_WR,
		OP_RD,
		OP_IDLE,
		OP_SER,
		OP_RAMP,
		OP_WAIT_WCLK,
		OP_QUIET,
		OP_PULSES,
		OP_COMPLETE
	} op_t;

	typedef struct packed {
		op_t               op;
		logic [ADR_W-1:0]  adr;
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] exp;
	} step_t;

	logic                 clk_i;
	logic                 rst_n_i;
	bus_req_t             bus_req;
	bus_rsp_t             bus_rsp;
	logic                 complete;
	logic                 readout_o;
	logic                 readout_fifo_rst_o;
	logic                 readout_test_pattern_o;
	logic [11:0]          regclear_o;
	logic [NUM_CHIPS-1:0] sin_o;
	logic [NUM_CHIPS-1:0] sclk_o;
	logic [NUM_CHIPS-1:0] pclk_o;
	logic [NUM_CHIPS-1:0] ramp_o;
	logic [NUM_CHIPS-1:0] wclk_o;

	step_t       steps[$];
	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit = 0;
	int          err_cnt = 0;

	// monitor state
	logic [SERIAL_W-1:0]  cap_word [NUM_CHIPS];
	int                   sclk_rises [NUM_CHIPS];
	int                   pclk_rises [NUM_CHIPS];
	logic [NUM_CHIPS-1:0] sclk_prev;
	logic [NUM_CHIPS-1:0] pclk_prev;
	logic [NUM_CHIPS-1:0] line_seen;
	int                   ramp_cycles;
	int                   wclk_rises;
	logic                 wclk_prev;
	int                   readout_pulses;
	int                   fifo_pulses;
	logic                 readout_prev;
	logic                 fifo_prev;

	lab4_controller #(
		.NUM_CHIPS(NUM_CHIPS)
	) i_dut (
		.clk_i                 (clk_i),
		.rst_n_i               (rst_n_i),
		.bus_req_i             (bus_req),
		.bus_rsp_o             (bus_rsp),
		.complete_i            (complete),
		.readout_o             (readout_o),
		.readout_fifo_rst_o    (readout_fifo_rst_o),
		.readout_test_pattern_o(readout_test_pattern_o),
		.regclear_o            (regclear_o),
		.sin_o                 (sin_o),
		.sclk_o                (sclk_o),
		.pclk_o                (pclk_o),
		.ramp_o                (ramp_o),
		.wclk_o                (wclk_o)
	);

	task automatic report_error(input string msg);
		err_cnt++;
		$display("error %0t: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	`include "tb_lab4_checks.svh"

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
			$display("timeout: run went past %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////
	// monitors, sampled mid-cycle
	//////////////////////////////////////////////////

	always @(negedge clk_i) begin
		for (int i = 0; i < NUM_CHIPS; i++) begin
			if (sclk_o[i] && !sclk_prev[i]) begin
				cap_word[i] = {cap_word[i][SERIAL_W-2:0], sin_o[i]};
				sclk_rises[i]++;
			end
			if (pclk_o[i] && !pclk_prev[i]) begin
				pclk_rises[i]++;
			end
		end
		line_seen = line_seen | sin_o | sclk_o | pclk_o;
		if (ramp_o != '0 && ramp_o != '1) begin
			report_error("ramp lines differ between chips");
		end
		if (wclk_o != '0 && wclk_o != '1) begin
			report_error("wilkinson clock lines differ between chips");
		end
		if (ramp_o[0] === 1'b1) begin
			ramp_cycles++;
		end
		if (wclk_o[0] && !wclk_prev) begin
			wclk_rises++;
		end
		if (readout_o && !readout_prev) begin
			readout_pulses++;
		end
		if (readout_fifo_rst_o && !fifo_prev) begin
			fifo_pulses++;
		end
		sclk_prev    = sclk_o;
		pclk_prev    = pclk_o;
		wclk_prev    = wclk_o[0];
		readout_prev = readout_o;
		fifo_prev    = readout_fifo_rst_o;
	end

	task automatic clear_monitors();
		for (int i = 0; i < NUM_CHIPS; i++) begin
			cap_word[i]   = '0;
			sclk_rises[i] = 0;
			pclk_rises[i] = 0;
		end
		line_seen      = '0;
		ramp_cycles    = 0;
		wclk_rises     = 0;
		readout_pulses = 0;
		fifo_pulses    = 0;
	endtask

	//////////////////////////////////////////////////
	// bus access
	//////////////////////////////////////////////////

	task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
			input logic [DATA_W-1:0] data, output bus_rsp_t rsp);
		@(posedge clk_i);
		bus_req.valid <= 1'b1;
		bus_req.we    <= we;
		bus_req.adr   <= adr;
		bus_req.wdata <= data;
		@(posedge clk_i);
		bus_req.valid <= 1'b0;
		bus_req.we    <= 1'b0;
		@(negedge clk_i);
		rsp = bus_rsp;
	endtask

	task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] data);
		bus_rsp_t rsp;
		bus_access(1'b1, adr, data, rsp);
		if (rsp.ack !== 1'b1) begin
			report_error($sformatf("write to address %0d not acknowledged", adr));
		end
	endtask

	// back-to-back reads until a status bit has been seen high and then low
	task automatic stream_status(input logic [ADR_W-1:0] adr, input int bit_idx,
			output int n_high);
		bus_rsp_t rsp;
		bit       seen;
		bit       done;
		n_high = 0;
		seen   = 1'b0;
		done   = 1'b0;
		@(posedge clk_i);
		bus_req.valid <= 1'b1;
		bus_req.we    <= 1'b0;
		bus_req.adr   <= adr;
		while (!done) begin
			@(posedge clk_i);
			@(negedge clk_i);
			rsp = bus_rsp;
			if (rsp.ack !== 1'b1) begin
				report_error("status read not acknowledged");
			end
			if (rsp.rdata[bit_idx]) begin
				seen = 1'b1;
				n_high++;
			end else if (seen) begin
				done = 1'b1;
			end
		end
		@(posedge clk_i);
		bus_req.valid <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////

	task automatic add_step(input op_t op, input logic [ADR_W-1:0] adr,
			input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
		step_t st;
		st.op   = op;
		st.adr  = adr;
		st.data = data;
		st.exp  = exp;
		steps.push_back(st);
	endtask

	task automatic build_table();
		// reset values
		add_step(OP_IDLE, REG_CONTROL, 32'h0, 32'h0);
		add_step(OP_RD, REG_CONTROL, 32'h0, 32'h0);
		add_step(OP_RD, REG_SHIFT_PRESCALE, 32'h0, 32'h0);
		add_step(OP_RD, REG_RAMP_DELAY, 32'h0, 32'h0);
		add_step(OP_RD, REG_WCLK_COUNT, 32'h0, 32'd1024);
		add_step(OP_RD, REG_SERIAL, 32'h0, 32'h0);
		add_step(OP_RD, REG_RAMP, 32'h0, 32'h0);
		add_step(OP_RD, REG_READOUT, 32'h0, 32'h0);
		// stored registers read back
		add_step(OP_WR, REG_CONTROL, 32'h0abc_0000, 32'h0);
		add_step(OP_RD, REG_CONTROL, 32'h0, 32'h0abc_0000);
		add_step(OP_IDLE, REG_CONTROL, 32'h0abc_0000, 32'h0);
		add_step(OP_WR, REG_SHIFT_PRESCALE, 32'h0000_0102, 32'h0);
		add_step(OP_RD, REG_SHIFT_PRESCALE, 32'h0, 32'h0000_0002);
		add_step(OP_WR, REG_RAMP_DELAY, 32'h0001_2345, 32'h0);
		add_step(OP_RD, REG_RAMP_DELAY, 32'h0, 32'h0000_2345);
		add_step(OP_WR, REG_WCLK_COUNT, 32'h0000_beef, 32'h0);
		add_step(OP_RD, REG_WCLK_COUNT, 32'h0, 32'h0000_beef);
		add_step(OP_WR, 5'd2, 32'hffff_ffff, 32'h0);
		add_step(OP_RD, 5'd2, 32'h0, 32'h0);
		// serial words, busy for 49*(P+1) cycles
		add_step(OP_WR, REG_SHIFT_PRESCALE, 32'd2, 32'h0);
		add_step(OP_SER, REG_SERIAL, 32'h0300_0000, 32'd147);
		add_step(OP_SER, REG_SERIAL, 32'h0b00_0000, 32'd147);
		add_step(OP_SER, REG_SERIAL, 32'h0f00_0000, 32'd147);
		add_step(OP_SER, REG_SERIAL, 32'h0c00_0000, 32'd147);
		add_step(OP_SER, REG_SERIAL, 32'h0d00_0000, 32'd147);
		add_step(OP_SER, REG_SERIAL, 32'h0e00_0000, 32'd147);
		add_step(OP_WR, REG_SHIFT_PRESCALE, 32'd0, 32'h0);
		add_step(OP_SER, REG_SERIAL, 32'h0000_0000, 32'd49);
		add_step(OP_IDLE, REG_CONTROL, 32'h0abc_0000, 32'h0);
		// ramp high D+1+2C cycles with C edges
		add_step(OP_WR, REG_RAMP_DELAY, 32'd5, 32'h0);
		add_step(OP_WR, REG_WCLK_COUNT, 32'd7, 32'h0);
		add_step(OP_RAMP, REG_RAMP, 32'd7, 32'd20);
		add_step(OP_RD, REG_RAMP, 32'h0, 32'h0);
		// abort in the wilkinson phase
		add_step(OP_WR, REG_WCLK_COUNT, 32'd100, 32'h0);
		add_step(OP_WR, REG_RAMP, 32'd1, 32'h0);
		add_step(OP_WAIT_WCLK, REG_RAMP, 32'd20, 32'h0);
		add_step(OP_WR, REG_CONTROL, 32'h0abc_0100, 32'h0);
		add_step(OP_QUIET, REG_RAMP, 32'd4, 32'h0);
		add_step(OP_RD, REG_RAMP, 32'h0, 32'h1);
		add_step(OP_WR, REG_WCLK_COUNT, 32'd3, 32'h0);
		add_step(OP_RAMP, REG_RAMP, 32'd3, 32'd12);
		add_step(OP_RD, REG_RAMP, 32'h0, 32'h0);
		// readout request and completion
		add_step(OP_WR, REG_READOUT, 32'h0000_0050, 32'h0);
		add_step(OP_PULSES, REG_READOUT, 32'd1, 32'd0);
		add_step(OP_RD, REG_READOUT, 32'h0, 32'h0000_0090);
		add_step(OP_IDLE, REG_CONTROL, 32'h0abc_0010, 32'h0);
		add_step(OP_COMPLETE, REG_READOUT, 32'h0, 32'h0);
		add_step(OP_RD, REG_READOUT, 32'h0, 32'h0000_0010);
		add_step(OP_WR, REG_READOUT, 32'h0000_0002, 32'h0);
		add_step(OP_PULSES, REG_READOUT, 32'd0, 32'd1);
		add_step(OP_RD, REG_READOUT, 32'h0, 32'h0);
		add_step(OP_IDLE, REG_CONTROL, 32'h0abc_0000, 32'h0);
	endtask

	// worst-case cycles per step, plus a fifth for margin
	function automatic int unsigned compute_limit();
		int unsigned total;
		total = RESET_CYCLES + 4;
		foreach (steps[i]) begin
			case (steps[i].op)
				OP_SER:          total += steps[i].exp + 8;
				OP_RAMP:         total += steps[i].exp + 6;
				OP_WAIT_WCLK:    total += steps[i].data;
				OP_QUIET:        total += steps[i].data + 2;
				OP_PULSES:       total += 4;
				default:         total += 3;
			endcase
		end
		return total + total / 5;
	endfunction

	//////////////////////////////////////////////////
	// step execution
	//////////////////////////////////////////////////

	task automatic run_step(input step_t st);
		bus_rsp_t             rsp;
		bus_rsp_t             exp_rsp;
		logic [31:0]          rnd;
		logic [SERIAL_W-1:0]  word;
		logic [SEL_W-1:0]     sel;
		logic [NUM_CHIPS-1:0] exp_mask;
		logic [NUM_CHIPS-1:0] got_mask;
		int                   n;
		case (st.op)
			OP_WR: bus_write(st.adr, st.data);
			OP_RD: begin
				bus_access(1'b0, st.adr, 32'h0, rsp);
				exp_rsp.ack   = 1'b1;
				exp_rsp.rdata = st.exp;
				check_rsp($sformatf("read address %0d", st.adr), rsp, exp_rsp);
			end
			OP_IDLE: begin
				check_level("serial lines", 32'(sin_o | sclk_o | pclk_o), 32'h0);
				check_level("ramp lines", 32'(ramp_o | wclk_o), 32'h0);
				check_level("readout pulses", 32'({readout_o, readout_fifo_rst_o}), 32'h0);
				check_level("test pattern", 32'(readout_test_pattern_o), 32'(st.data[4]));
				check_level("regclear", 32'(regclear_o), 32'(st.data[27:16]));
			end
			OP_SER: begin
				rnd  = $urandom();
				word = rnd[SERIAL_W-1:0];
				sel  = st.data[27:24];
				// broadcast, one chip, or no chip at all
				if (sel == SEL_ALL) begin
					exp_mask = '1;
				end else if (int'(sel) < NUM_CHIPS) begin
					exp_mask = NUM_CHIPS'(1) << sel;
				end else begin
					exp_mask = '0;
				end
				clear_monitors();
				bus_write(REG_SERIAL, {1'b1, 3'b000, sel, word});
				stream_status(REG_SERIAL, 31, n);
				check_count("serial busy cycles", wilk_count_t'(n), wilk_count_t'(st.exp));
				got_mask = line_seen;
				for (int i = 0; i < NUM_CHIPS; i++) begin
					check_serial($sformatf("serial chip %0d", i), cap_word[i],
						exp_mask[i] ? word : '0, got_mask, exp_mask);
					if (exp_mask[i]) begin
						check_count("sclk edges", wilk_count_t'(sclk_rises[i]), 16'd24);
						check_count("pclk pulses", wilk_count_t'(pclk_rises[i]), 16'd1);
					end
				end
				bus_access(1'b0, REG_SERIAL, 32'h0, rsp);
				exp_rsp.ack   = 1'b1;
				exp_rsp.rdata = {4'b0000, sel, word};
				check_rsp("serial readback", rsp, exp_rsp);
			end
			OP_RAMP: begin
				clear_monitors();
				bus_write(REG_RAMP, 32'd1);
				stream_status(REG_RAMP, 0, n);
				check_count("ramp high cycles", wilk_count_t'(ramp_cycles), wilk_count_t'(st.exp));
				check_count("wilkinson edges", wilk_count_t'(wclk_rises), wilk_count_t'(st.data));
			end
			OP_WAIT_WCLK: begin
				while (wclk_o[0] !== 1'b1) begin
					@(negedge clk_i);
				end
			end
			OP_QUIET: begin
				@(negedge clk_i);
				repeat (st.data) begin
					check_level("ramp after abort", 32'(ramp_o), 32'h0);
					check_level("wilkinson clock after abort", 32'(wclk_o), 32'h0);
					@(negedge clk_i);
				end
			end
			OP_PULSES: begin
				repeat (3) @(negedge clk_i);
				check_count("readout pulses", wilk_count_t'(readout_pulses), wilk_count_t'(st.data));
				check_count("fifo reset pulses", wilk_count_t'(fifo_pulses), wilk_count_t'(st.exp));
				readout_pulses = 0;
				fifo_pulses    = 0;
			end
			OP_COMPLETE: begin
				@(posedge clk_i);
				complete <= 1'b1;
				@(posedge clk_i);
				complete <= 1'b0;
			end
			default: report_error("unknown step in stimulus table");
		endcase
	endtask

	initial begin
		void'($urandom(32'hc3c6_575b));
		rst_n_i  = 1'b0;
		bus_req  = '0;
		complete = 1'b0;
		build_table();
		cycle_limit = compute_limit();
		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_n_i <= 1'b1;
		@(negedge clk_i);
		clear_monitors();
		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		if (err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== hdl/lab4_controller.sv ====
`timescale 1ns/1ps

module lab4_controller #(
	parameter int NUM_CHIPS = 12
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  lab4_pkg::bus_req_t    bus_req_i,
	output lab4_pkg::bus_rsp_t    bus_rsp_o,
	input  logic                  complete_i,
	output logic                  readout_o,
	output logic                  readout_fifo_rst_o,
	output logic                  readout_test_pattern_o,
	output logic [11:0]           regclear_o,
	output logic [NUM_CHIPS-1:0]  sin_o,
	output logic [NUM_CHIPS-1:0]  sclk_o,
	output logic [NUM_CHIPS-1:0]  pclk_o,
	output logic [NUM_CHIPS-1:0]  ramp_o,
	output logic [NUM_CHIPS-1:0]  wclk_o
);

	import lab4_pkg::*;

	serial_cmd_t  serial_cmd;
	logic         serial_busy;
	ramp_cfg_t    ramp_cfg;
	logic         ramp_start;
	logic         ramp_done;
	readout_ctl_t readout_ctl;
	prescale_t    prescale;

	lab4_ctrl_regs u_regs (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.bus_req_i    (bus_req_i),
		.bus_rsp_o    (bus_rsp_o),
		.serial_cmd_o (serial_cmd),
		.serial_busy_i(serial_busy),
		.ramp_cfg_o   (ramp_cfg),
		.ramp_start_o (ramp_start),
		.ramp_done_i  (ramp_done),
		.readout_ctl_o(readout_ctl),
		.complete_i   (complete_i),
		.prescale_o   (prescale),
		.regclear_o   (regclear_o)
	);

	lab4_ramp_fsm #(
		.NUM_CHIPS(NUM_CHIPS)
	) u_ramp (
		.clk_i  (clk_i),
		.rst_n_i(rst_n_i),
		.start_i(ramp_start),
		.cfg_i  (ramp_cfg),
		.done_o (ramp_done),
		.ramp_o (ramp_o),
		.wclk_o (wclk_o)
	);

	lab4_serial_shifter #(
		.NUM_CHIPS(NUM_CHIPS)
	) u_shifter (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.cmd_i     (serial_cmd),
		.prescale_i(prescale),
		.busy_o    (serial_busy),
		.sin_o     (sin_o),
		.sclk_o    (sclk_o),
		.pclk_o    (pclk_o)
	);

	// readout lines to the downstream logic
	assign readout_o              = readout_ctl.start;
	assign readout_fifo_rst_o     = readout_ctl.fifo_rst;
	assign readout_test_pattern_o = readout_ctl.test_pattern;

endmodule

// ==== hdl/lab4_serial_shifter.sv ====
`timescale 1ns/1ps

module lab4_serial_shifter #(
	parameter int NUM_CHIPS = 12
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  lab4_pkg::serial_cmd_t cmd_i,
	input  lab4_pkg::prescale_t   prescale_i,
	output logic                  busy_o,
	output logic [NUM_CHIPS-1:0]  sin_o,
	output logic [NUM_CHIPS-1:0]  sclk_o,
	output logic [NUM_CHIPS-1:0]  pclk_o
);

	import lab4_pkg::*;

	localparam int BIT_W = $clog2(SERIAL_W);

	logic                busy_q;
	logic                sclk_q;
	logic                latch_q;
	logic [BIT_W-1:0]    bit_cnt_q;
	logic [SERIAL_W-1:0] shreg_q;
	logic [SEL_W-1:0]    sel_q;
	logic                go_accept;
	logic                tmr_load;
	logic                tmr_expired;
	logic                sin;
	logic [NUM_CHIPS-1:0] chip_en;

	// go while busy is dropped here
	assign go_accept = cmd_i.go && !busy_q;

	// each half-bit and the latch phase last P+1 cycles
	assign tmr_load = go_accept || (busy_q && tmr_expired && !latch_q);

	lab4_interval_timer #(
		.count_t(prescale_t)
	) u_timer (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.load_i   (tmr_load),
		.value_i  (prescale_i),
		.expired_o(tmr_expired)
	);

	//////////////////////////////////////////////////
	// phase stepping
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			busy_q    <= 1'b0;
			sclk_q    <= 1'b0;
			latch_q   <= 1'b0;
			bit_cnt_q <= '0;
		end else if (go_accept) begin
			busy_q    <= 1'b1;
			sclk_q    <= 1'b0;
			latch_q   <= 1'b0;
			bit_cnt_q <= '0;
		end else if (busy_q && tmr_expired) begin
			if (latch_q) begin
				busy_q  <= 1'b0;
				latch_q <= 1'b0;
			end else if (!sclk_q) begin
				sclk_q <= 1'b1;
			end else begin
				sclk_q <= 1'b0;
				if (bit_cnt_q == BIT_W'(SERIAL_W - 1)) begin
					latch_q <= 1'b1;
				end else begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
				end
			end
		end
	end

	// msb first, next bit shows after the sclk high phase
	always_ff @(posedge clk_i) begin
		if (go_accept) begin
			shreg_q <= cmd_i.data;
			sel_q   <= cmd_i.sel;
		end else if (busy_q && tmr_expired && sclk_q && !latch_q) begin
			shreg_q <= {shreg_q[SERIAL_W-2:0], 1'b0};
		end
	end

	assign sin = busy_q && !latch_q && shreg_q[SERIAL_W-1];

	//////////////////////////////////////////////////
	// per-chip fanout
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < NUM_CHIPS; i++) begin
			chip_en[i] = (sel_q == SEL_ALL) || (32'(sel_q) == i);
		end
	end

	assign busy_o = busy_q;
	assign sin_o  = chip_en & {NUM_CHIPS{sin}};
	assign sclk_o = chip_en & {NUM_CHIPS{sclk_q}};
	assign pclk_o = chip_en & {NUM_CHIPS{latch_q}};

	a_lines_within_busy: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(sclk_q || latch_q) |-> busy_q
	);

endmodule

// ==== hdl/lab4_ramp_fsm.sv ====
`timescale 1ns/1ps

module lab4_ramp_fsm #(
	parameter int NUM_CHIPS = 12
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  start_i,
	input  lab4_pkg::ramp_cfg_t   cfg_i,
	output logic                  done_o,
	output logic [NUM_CHIPS-1:0]  ramp_o,
	output logic [NUM_CHIPS-1:0]  wclk_o
);

	import lab4_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DELAY,
		ST_WILK
	} state_t;

	state_t      state_q;
	logic        wclk_q;
	logic        done_q;
	logic        ramp;
	logic        tmr_load;
	logic        tmr_expired;
	wilk_count_t tmr_value;

	assign ramp = (state_q != ST_IDLE);

	// delay phase lasts D+1 cycles, wilkinson phase 2C cycles
	always_comb begin
		tmr_load  = 1'b0;
		tmr_value = cfg_i.delay;
		if (state_q == ST_IDLE && start_i) begin
			tmr_load = 1'b1;
		end else if (state_q == ST_DELAY && tmr_expired && cfg_i.count != '0) begin
			tmr_load  = 1'b1;
			tmr_value = wilk_count_t'({cfg_i.count, 1'b0} - 17'd1);
		end
	end

	lab4_interval_timer #(
		.count_t(wilk_count_t)
	) u_timer (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.load_i   (tmr_load),
		.value_i  (tmr_value),
		.expired_o(tmr_expired)
	);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			wclk_q  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (cfg_i.abort) begin
				state_q <= ST_IDLE;
				wclk_q  <= 1'b0;
			end else begin
				case (state_q)
					ST_IDLE: begin
						if (start_i) begin
							state_q <= ST_DELAY;
						end
					end
					ST_DELAY: begin
						wclk_q <= 1'b0;
						if (tmr_expired) begin
							// zero count means ramp only
							if (cfg_i.count == '0) begin
								state_q <= ST_IDLE;
								done_q  <= 1'b1;
							end else begin
								state_q <= ST_WILK;
							end
						end
					end
					ST_WILK: begin
						if (tmr_expired) begin
							state_q <= ST_IDLE;
							wclk_q  <= 1'b0;
							done_q  <= 1'b1;
						end else begin
							wclk_q <= ~wclk_q;
						end
					end
					default: state_q <= ST_IDLE;
				endcase
			end
		end
	end

	assign done_o = done_q;
	assign ramp_o = {NUM_CHIPS{ramp}};
	assign wclk_o = {NUM_CHIPS{wclk_q}};

	a_wclk_inside_ramp: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!ramp |-> !wclk_q
	);

endmodule

// ==== hdl/lab4_ctrl_regs.sv ====
`timescale 1ns/1ps

module lab4_ctrl_regs (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  lab4_pkg::bus_req_t     bus_req_i,
	output lab4_pkg::bus_rsp_t     bus_rsp_o,
	output lab4_pkg::serial_cmd_t  serial_cmd_o,
	input  logic                   serial_busy_i,
	output lab4_pkg::ramp_cfg_t    ramp_cfg_o,
	output logic                   ramp_start_o,
	input  logic                   ramp_done_i,
	output lab4_pkg::readout_ctl_t readout_ctl_o,
	input  logic                   complete_i,
	output lab4_pkg::prescale_t    prescale_o,
	output logic [11:0]            regclear_o
);

	import lab4_pkg::*;

	logic                wr;
	logic [DATA_W-1:0]   wdata;
	logic [DATA_W-1:0]   rdata_d;
	logic [DATA_W-1:0]   rdata_q;
	logic                ack_q;

	logic [11:0]         regclear_q;
	logic                abort_q;
	prescale_t           prescale_q;
	wilk_count_t         ramp_delay_q;
	wilk_count_t         wclk_count_q;
	logic [SERIAL_W-1:0] serial_data_q;
	logic [SEL_W-1:0]    serial_sel_q;
	logic                serial_go_q;
	logic                ramp_start_q;
	logic                ramp_pending_q;
	logic                readout_req_q;
	logic                readout_start_q;
	logic                fifo_rst_q;
	logic                test_pattern_q;
	logic                readout_pending_q;

	assign wr    = bus_req_i.valid && bus_req_i.we;
	assign wdata = bus_req_i.wdata;

	//////////////////////////////////////////////////
	// read mux, sampled in the request cycle
	//////////////////////////////////////////////////

	always_comb begin
		rdata_d = '0;
		case (bus_req_i.adr)
			REG_CONTROL:        rdata_d[27:16] = regclear_q;
			REG_SHIFT_PRESCALE: rdata_d[7:0] = prescale_q;
			REG_RAMP_DELAY:     rdata_d[15:0] = ramp_delay_q;
			REG_WCLK_COUNT:     rdata_d[15:0] = wclk_count_q;
			REG_SERIAL:         rdata_d = {serial_busy_i, 3'b000, serial_sel_q, serial_data_q};
			REG_RAMP:           rdata_d[0] = ramp_pending_q;
			REG_READOUT: begin
				rdata_d[7] = readout_pending_q;
				rdata_d[4] = test_pattern_q;
			end
			default:            rdata_d = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		rdata_q <= rdata_d;
	end

	//////////////////////////////////////////////////
	// write decode and command pulses
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_q             <= 1'b0;
			regclear_q        <= '0;
			abort_q           <= 1'b0;
			prescale_q        <= SHIFT_PRESCALE_DEFAULT;
			ramp_delay_q      <= RAMP_DELAY_DEFAULT;
			wclk_count_q      <= WCLK_COUNT_DEFAULT;
			serial_data_q     <= '0;
			serial_sel_q      <= '0;
			serial_go_q       <= 1'b0;
			ramp_start_q      <= 1'b0;
			ramp_pending_q    <= 1'b0;
			readout_req_q     <= 1'b0;
			readout_start_q   <= 1'b0;
			fifo_rst_q        <= 1'b0;
			test_pattern_q    <= 1'b0;
			readout_pending_q <= 1'b0;
		end else begin
			ack_q           <= bus_req_i.valid;
			abort_q         <= wr && (bus_req_i.adr == REG_CONTROL) && wdata[8];
			serial_go_q     <= wr && (bus_req_i.adr == REG_SERIAL) && wdata[31];
			ramp_start_q    <= wr && (bus_req_i.adr == REG_RAMP) && wdata[0];
			readout_req_q   <= wr && (bus_req_i.adr == REG_READOUT) && wdata[6];
			fifo_rst_q      <= wr && (bus_req_i.adr == REG_READOUT) && wdata[1];
			// extra stage puts readout two cycles after the request
			readout_start_q <= readout_req_q;

			if (wr && bus_req_i.adr == REG_CONTROL) begin
				regclear_q <= wdata[27:16];
			end
			if (wr && bus_req_i.adr == REG_SHIFT_PRESCALE) begin
				prescale_q <= wdata[7:0];
			end
			if (wr && bus_req_i.adr == REG_RAMP_DELAY) begin
				ramp_delay_q <= wdata[15:0];
			end
			if (wr && bus_req_i.adr == REG_WCLK_COUNT) begin
				wclk_count_q <= wdata[15:0];
			end
			if (wr && bus_req_i.adr == REG_SERIAL) begin
				serial_data_q <= wdata[SERIAL_W-1:0];
				serial_sel_q  <= wdata[27:24];
			end
			if (wr && bus_req_i.adr == REG_READOUT) begin
				test_pattern_q <= wdata[4];
			end

			// done clears, start sets
			if (ramp_done_i) begin
				ramp_pending_q <= 1'b0;
			end else if (wr && bus_req_i.adr == REG_RAMP && wdata[0]) begin
				ramp_pending_q <= 1'b1;
			end

			// completion wins over a start in the same cycle
			if (complete_i) begin
				readout_pending_q <= 1'b0;
			end else if (wr && bus_req_i.adr == REG_READOUT && wdata[6]) begin
				readout_pending_q <= 1'b1;
			end
		end
	end

	assign bus_rsp_o.ack   = ack_q;
	assign bus_rsp_o.rdata = rdata_q;

	assign serial_cmd_o.go   = serial_go_q;
	assign serial_cmd_o.sel  = serial_sel_q;
	assign serial_cmd_o.data = serial_data_q;

	assign ramp_cfg_o.delay = ramp_delay_q;
	assign ramp_cfg_o.count = wclk_count_q;
	assign ramp_cfg_o.abort = abort_q;
	assign ramp_start_o     = ramp_start_q;

	assign readout_ctl_o.start        = readout_start_q;
	assign readout_ctl_o.fifo_rst     = fifo_rst_q;
	assign readout_ctl_o.test_pattern = test_pattern_q;

	assign prescale_o = prescale_q;
	assign regclear_o = regclear_q;

	a_ack_follows_req: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		bus_rsp_o.ack |-> $past(bus_req_i.valid)
	);

endmodule

// ==== hdl/lab4_interval_timer.sv ====
`timescale 1ns/1ps

module lab4_interval_timer #(
	parameter type count_t = logic [7:0]
) (
	input  logic   clk_i,
	input  logic   rst_n_i,
	input  logic   load_i,
	input  count_t value_i,
	output logic   expired_o
);

	count_t cnt_q;
	logic   active_q;

	// load of N gives expiry N+1 cycles later
	assign expired_o = active_q && (cnt_q == '0);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			active_q <= 1'b0;
		end else if (load_i) begin
			active_q <= 1'b1;
		end else if (expired_o) begin
			active_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			cnt_q <= value_i;
		end else if (active_q && !expired_o) begin
			cnt_q <= count_t'(cnt_q - 1'b1);
		end
	end

	// a reload in the expiry cycle restarts the count
	a_load_wins: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(load_i && expired_o && value_i != '0) |=> !expired_o
	);

endmodule

// ==== hdl/lab4_pkg.sv ====
package lab4_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int DATA_W   = 32;
	localparam int ADR_W    = 5;
	localparam int SERIAL_W = 24;
	localparam int SEL_W    = 4;

	// select value that broadcasts to every chip
	localparam logic [SEL_W-1:0] SEL_ALL = 4'd15;

	//////////////////////////////////////////////////
	// register map, word addresses
	//////////////////////////////////////////////////

	localparam logic [ADR_W-1:0] REG_CONTROL        = 5'd0;
	localparam logic [ADR_W-1:0] REG_SHIFT_PRESCALE = 5'd1;
	localparam logic [ADR_W-1:0] REG_RAMP_DELAY     = 5'd3;
	localparam logic [ADR_W-1:0] REG_WCLK_COUNT     = 5'd4;
	localparam logic [ADR_W-1:0] REG_SERIAL         = 5'd6;
	localparam logic [ADR_W-1:0] REG_RAMP           = 5'd7;
	localparam logic [ADR_W-1:0] REG_READOUT        = 5'd22;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef logic [7:0]  prescale_t;
	typedef logic [15:0] wilk_count_t;

	// reset defaults
	localparam wilk_count_t WCLK_COUNT_DEFAULT     = 16'd1024;
	localparam wilk_count_t RAMP_DELAY_DEFAULT     = 16'd0;
	localparam prescale_t   SHIFT_PRESCALE_DEFAULT = 8'd0;

	// host request, one word per cycle
	typedef struct packed {
		logic              valid;
		logic              we;
		logic [ADR_W-1:0]  adr;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	// answer arrives one cycle after the request
	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

	typedef struct packed {
		logic                go;
		logic [SEL_W-1:0]    sel;
		logic [SERIAL_W-1:0] data;
	} serial_cmd_t;

	typedef struct packed {
		wilk_count_t delay;
		wilk_count_t count;
		logic        abort;
	} ramp_cfg_t;

	typedef struct packed {
		logic start;
		logic fifo_rst;
		logic test_pattern;
	} readout_ctl_t;

endpackage
